//--- sim.f
+incdir+tb
design/opq_pkg.sv
design/opq_conv_if.sv
design/opq_fifo.sv
design/opq_operand_buffer.sv
design/opq_convert.sv
design/opq_sequencer.sv
design/operand_queue.sv
tb/tb_operand_queue.sv

//--- run.sh
#!/bin/sh
# Build and run the operand queue testbench with Verilator.
# The exit status is non-zero when the build or the simulation fails.
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -Wno-fatal -f sim.f \
       --top-module tb_operand_queue -Mdir obj_dir -o sim_operand_queue \
  && ./obj_dir/sim_operand_queue \
  || exit 1

//--- tb/tb_opq_model.svh
/*
  Expected output words of the operand queue, built from the conversion rules.
  Used inside tb_operand_queue after the opq_pkg import.
*/

// All ones in the low w bits
function automatic logic [ElenWidth-1:0] width_mask(input int unsigned w);
  if (w >= ElenWidth) begin
    return '1;
  end
  return (64'd1 << w) - 64'd1;
endfunction

// Expected word for one transfer, sel is the byte offset of the first source element
function automatic operand_word_u expected_word(
  input logic [ConvWidth-1:0] conv,
  input logic [EewWidth-1:0]  eew,
  input logic [1:0]           ntr,
  input logic                 lane_zero,
  input int unsigned          sel,
  input logic [ElenWidth-1:0] word
);
  operand_word_u res;
  int unsigned   sew;
  int unsigned   dew;
  int unsigned   factor;
  logic [63:0]   src;
  logic [63:0]   elem;
  logic [63:0]   smask;
  logic [63:0]   dmask;
  logic [63:0]   neutral;
  logic          sext;

  res.d  = word;
  sew    = 8 << eew;
  sext   = (conv == ConvSExt2) || (conv == ConvSExt4);
  factor = 0;
  if ((conv == ConvSExt2 || conv == ConvZExt2) && eew != EW64) begin
    factor = 2;
  end
  if ((conv == ConvSExt4 || conv == ConvZExt4) && (eew == EW8 || eew == EW16)) begin
    factor = 4;
  end
  smask = width_mask(sew);

  if (factor != 0) begin
    dew   = sew * factor;
    dmask = width_mask(dew);
    for (int i = 0; i < ElenWidth / dew; i++) begin
      src  = (word >> (sel * 8 + i * sew)) & smask;
      elem = src;
      if (sext && src[sew-1]) begin
        elem = elem | (dmask & ~smask);
      end
      res.d = (res.d & ~(dmask << (i * dew))) | (elem << (i * dew));
    end
  end else if (conv == ConvIntRed) begin
    // Top bit from ntr[1], every lower bit from ntr[0]
    neutral = ({63'b0, ntr[1]} << (sew - 1)) | (ntr[0] ? (smask >> 1) : 64'b0);
    for (int i = 0; i < ElenWidth / sew; i++) begin
      if (!(lane_zero && i == 0)) begin
        res.d = (res.d & ~(smask << (i * sew))) | (neutral << (i * sew));
      end
    end
  end
  return res;
endfunction

task automatic check_operand(input operand_word_u exp_w, input operand_word_u act_w);
  if (act_w.d !== exp_w.d) begin
    fail_run($sformatf("ERROR %0t operand_o expected %h got %h", $time, exp_w.d, act_w.d));
  end
endtask

task automatic check_target_fu(input logic [TargetFuWidth-1:0] exp_fu,
                               input logic [TargetFuWidth-1:0] act_fu);
  if (act_fu !== exp_fu) begin
    fail_run($sformatf("ERROR %0t operand_target_fu_o expected %h got %h",
                       $time, exp_fu, act_fu));
  end
endtask

task automatic check_ready(input logic exp_rdy, input logic act_rdy);
  if (act_rdy !== exp_rdy) begin
    fail_run($sformatf("ERROR %0t operand_queue_ready_o expected %b got %b",
                       $time, exp_rdy, act_rdy));
  end
endtask

//--- tb/tb_operand_queue.sv
/*
  Testbench of the operand queue with BufferDepth 2. Commands run one at a time,
  outputs are sampled on the falling edge, inputs change 2 ns after the rising edge.
*/
`timescale 1ns/1ps

module tb_operand_queue;
  import opq_pkg::*;

  localparam int unsigned BufferDepth   = 2;
  localparam int          ClkPeriod     = 40;
  localparam int unsigned CyclesPerWord = 40;
  localparam int unsigned TimeoutSlack  = 100;
  localparam int          Seed          = 32'h9e6e;

  logic                     clk_i, rst_ni;
  logic [LaneIdWidth-1:0]   lane_id_i;
  logic                     cmd_valid_i;
  logic [ConvWidth-1:0]     cmd_conv_i;
  logic [EewWidth-1:0]      cmd_eew_i;
  logic [1:0]               cmd_ntr_red_i;
  logic [VlWidth-1:0]       cmd_vl_i;
  logic [TargetFuWidth-1:0] cmd_target_fu_i;
  logic [ElenWidth-1:0]     operand_i;
  logic                     operand_valid_i, operand_issued_i, operand_queue_ready_o;
  logic [ElenWidth-1:0]     operand_o;
  logic [TargetFuWidth-1:0] operand_target_fu_o;
  logic                     operand_valid_o, operand_ready_i;

  // Words still to be read, expected outputs and their tags
  logic [ElenWidth-1:0]     read_q[$];
  operand_word_u            exp_word_q[$];
  logic [TargetFuWidth-1:0] exp_fu_q[$];

  int          data_seed     = Seed;
  int          ready_seed    = Seed;
  int unsigned planned_words = 0;
  int unsigned cycles        = 0;
  // Consumer ready: 0 always high, 1 always low, 2 random
  int unsigned ready_mode    = 0;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  `include "tb_opq_model.svh"

  operand_queue #(
    .BufferDepth (BufferDepth)
  ) operand_queue_inst (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .lane_id_i             (lane_id_i),
    .cmd_valid_i           (cmd_valid_i),
    .cmd_conv_i            (cmd_conv_i),
    .cmd_eew_i             (cmd_eew_i),
    .cmd_ntr_red_i         (cmd_ntr_red_i),
    .cmd_vl_i              (cmd_vl_i),
    .cmd_target_fu_i       (cmd_target_fu_i),
    .operand_i             (operand_i),
    .operand_valid_i       (operand_valid_i),
    .operand_issued_i      (operand_issued_i),
    .operand_queue_ready_o (operand_queue_ready_o),
    .operand_o             (operand_o),
    .operand_target_fu_o   (operand_target_fu_o),
    .operand_valid_o       (operand_valid_o),
    .operand_ready_i       (operand_ready_i)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever begin
      #(ClkPeriod / 2) clk_i = ~clk_i;
    end
  end

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  // Push one command, then walk the counting rules to queue reads and expected words
  task automatic start_command(input logic [ConvWidth-1:0] conv,
                               input logic [EewWidth-1:0] eew, input logic [1:0] ntr,
                               input int unsigned vl, input logic [TargetFuWidth-1:0] fu);
    logic [ElenWidth-1:0] word;
    int unsigned          count;
    int unsigned          sel;
    int unsigned          per_out;
    int unsigned          step;
    logic                 word_done;

    count   = 0;
    per_out = 8 >> eew;
    step    = 8;
    if (conv == ConvSExt2 || conv == ConvZExt2) begin
      per_out = per_out / 2;
      step    = 4;
    end
    if (conv == ConvSExt4 || conv == ConvZExt4) begin
      per_out = per_out / 4;
      step    = 2;
    end
    if (conv == ConvIntRed) begin
      per_out = 1;
    end
    @(posedge clk_i);
    #2;
    cmd_valid_i     = 1'b1;
    cmd_conv_i      = conv;
    cmd_eew_i       = eew;
    cmd_ntr_red_i   = ntr;
    cmd_vl_i        = VlWidth'(vl);
    cmd_target_fu_i = fu;
    @(posedge clk_i);
    #2;
    cmd_valid_i = 1'b0;
    while (count < vl) begin
      word = {$random(data_seed), $random(data_seed)};
      read_q.push_back(word);
      sel       = 0;
      word_done = 1'b0;
      while (!word_done) begin
        exp_word_q.push_back(expected_word(conv, eew, ntr, lane_id_i == '0, sel, word));
        exp_fu_q.push_back(fu);
        planned_words++;
        count     = count + per_out;
        sel       = sel + step;
        word_done = (sel >= 8) || (count >= vl);
      end
    end
  endtask

  task automatic wait_drained();
    while (exp_word_q.size() != 0 || read_q.size() != 0) begin
      @(posedge clk_i);
    end
    @(posedge clk_i);
  endtask

  // Register file: one read per cycle while credit allows, data one cycle later
  initial begin : requester
    logic [ElenWidth-1:0] next_word;
    logic                 pending;

    pending          = 1'b0;
    next_word        = '0;
    operand_i        = '0;
    operand_valid_i  = 1'b0;
    operand_issued_i = 1'b0;
    @(posedge rst_ni);
    forever begin
      @(posedge clk_i);
      #2;
      operand_valid_i = pending;
      operand_i       = next_word;
      pending         = 1'b0;
      if (operand_queue_ready_o && read_q.size() > 0) begin
        next_word = read_q.pop_front();
        pending   = 1'b1;
      end
      operand_issued_i = pending;
    end
  end

  initial begin : ready_driver
    operand_ready_i = 1'b1;
    forever begin
      @(posedge clk_i);
      #2;
      case (ready_mode)
        0:       operand_ready_i = 1'b1;
        1:       operand_ready_i = 1'b0;
        default: operand_ready_i = 1'($random(ready_seed));
      endcase
    end
  end

  //////////////////////////////
  // Compare and timeout
  //////////////////////////////

  initial begin : compare
    operand_word_u            held_word;
    logic [TargetFuWidth-1:0] held_fu;
    logic                     stalled;

    stalled   = 1'b0;
    held_word = '0;
    held_fu   = '0;
    forever begin
      @(negedge clk_i);
      if (rst_ni) begin
        // A stalled output must hold word and tag
        if (stalled) begin
          if (!operand_valid_o) begin
            fail_run("operand_valid_o dropped while the consumer was stalling");
          end
          check_operand(held_word, operand_o);
          check_target_fu(held_fu, operand_target_fu_o);
        end
        if (operand_valid_o && operand_ready_i) begin
          if (exp_word_q.size() == 0) begin
            fail_run("An output word was transferred when none was expected");
          end
          check_operand(exp_word_q.pop_front(), operand_o);
          check_target_fu(exp_fu_q.pop_front(), operand_target_fu_o);
        end
        stalled   = operand_valid_o && !operand_ready_i;
        held_word = operand_o;
        held_fu   = operand_target_fu_o;
      end
    end
  end

  initial begin : watchdog
    forever begin
      @(posedge clk_i);
      cycles++;
      if (cycles > CyclesPerWord * planned_words + TimeoutSlack) begin
        fail_run("Timeout: the expected output words did not all arrive");
      end
    end
  end

  initial begin : main
    logic        ready_fell;
    int unsigned issued;

    rst_ni          = 1'b0;
    lane_id_i       = '0;
    cmd_valid_i     = 1'b0;
    cmd_conv_i      = ConvNone;
    cmd_eew_i       = EW8;
    cmd_ntr_red_i   = 2'b00;
    cmd_vl_i        = '0;
    cmd_target_fu_i = '0;
    repeat (2) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    @(negedge clk_i);
    if (operand_valid_o || !operand_queue_ready_o) begin
      fail_run("After reset the output was valid or the queue was not ready");
    end

    // Pass-through at every element width
    for (int e = 0; e < 4; e++) begin
      start_command(ConvNone, EewWidth'(e), 2'b00, 13, TargetFuWidth'(e));
      wait_drained();
    end

    // Sign extension by 2, odd counts end on a low half
    start_command(ConvSExt2, EW8, 2'b00, 12, 2'd1);
    wait_drained();
    start_command(ConvSExt2, EW16, 2'b00, 7, 2'd2);
    wait_drained();
    start_command(ConvSExt2, EW32, 2'b00, 5, 2'd3);
    wait_drained();

    // Zero extension by 4
    start_command(ConvZExt4, EW8, 2'b00, 16, 2'd0);
    wait_drained();
    start_command(ConvZExt4, EW16, 2'b00, 6, 2'd1);
    wait_drained();

    // Integer reduction on lane 0, then on lane 3
    for (int n = 0; n < 4; n++) begin
      start_command(ConvIntRed, EewWidth'(n), 2'(n), 3, TargetFuWidth'(n));
      wait_drained();
    end
    @(posedge clk_i);
    #2;
    lane_id_i = LaneIdWidth'(3);
    for (int n = 0; n < 4; n++) begin
      start_command(ConvIntRed, EewWidth'(3 - n), 2'(n), 2, TargetFuWidth'(3 - n));
      wait_drained();
    end

    // Back-pressure fills the credit, then random ready drains it
    ready_mode = 1;
    start_command(ConvNone, EW8, 2'b00, 32, 2'd2);
    issued     = 0;
    ready_fell = 1'b0;
    for (int c = 0; c < 20 && !ready_fell; c++) begin
      @(negedge clk_i);
      // Nothing pops, so each issued read keeps its credit
      check_ready(issued < BufferDepth, operand_queue_ready_o);
      ready_fell = !operand_queue_ready_o;
      if (operand_issued_i) begin
        issued++;
      end
    end
    if (!ready_fell) begin
      fail_run("operand_queue_ready_o stayed high while the consumer was stalling");
    end
    repeat (6) @(posedge clk_i);
    ready_mode = 2;
    wait_drained();
    start_command(ConvSExt2, EW16, 2'b00, 16, 2'd1);
    wait_drained();
    ready_mode = 0;
    repeat (2) @(posedge clk_i);

    if (exp_word_q.size() == 0 && !operand_valid_o) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      fail_run("Expected output words were left over at the end of the run");
    end
  end

endmodule

//--- design/operand_queue.sv
/*
  Operand queue of one vector lane. A command must be pushed before its reads are
  issued, and the requester never pushes into a full command FIFO.
*/
`timescale 1ns/1ps

module operand_queue #(
  parameter int unsigned BufferDepth = 2
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic [opq_pkg::LaneIdWidth-1:0]   lane_id_i,
  // Command from the operand requester
  input  logic                              cmd_valid_i,
  input  logic [opq_pkg::ConvWidth-1:0]     cmd_conv_i,
  input  logic [opq_pkg::EewWidth-1:0]      cmd_eew_i,
  input  logic [1:0]                        cmd_ntr_red_i,
  input  logic [opq_pkg::VlWidth-1:0]       cmd_vl_i,
  input  logic [opq_pkg::TargetFuWidth-1:0] cmd_target_fu_i,
  // Register file side
  input  logic [opq_pkg::ElenWidth-1:0]     operand_i,
  input  logic                              operand_valid_i,
  input  logic                              operand_issued_i,
  output logic                              operand_queue_ready_o,
  // Functional unit side
  output logic [opq_pkg::ElenWidth-1:0]     operand_o,
  output logic [opq_pkg::TargetFuWidth-1:0] operand_target_fu_o,
  output logic                              operand_valid_o,
  input  logic                              operand_ready_i
);
  import opq_pkg::*;

  logic [CmdWidth-1:0]  cmd_in, cmd_head;
  logic                 cmd_empty, cmd_pop;
  logic [ElenWidth-1:0] ibuf_head;
  logic                 ibuf_head_valid, ibuf_pop;

  opq_conv_if conv_bus ();

  // Pack the command at the package offsets
  assign cmd_in[CmdConvLsb +: ConvWidth]   = cmd_conv_i;
  assign cmd_in[CmdEewLsb +: EewWidth]     = cmd_eew_i;
  assign cmd_in[CmdNtrLsb +: 2]            = cmd_ntr_red_i;
  assign cmd_in[CmdVlLsb +: VlWidth]       = cmd_vl_i;
  assign cmd_in[CmdFuLsb +: TargetFuWidth] = cmd_target_fu_i;

  opq_fifo #(
    .Width (CmdWidth),
    .Depth (BufferDepth)
  ) cmd_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (cmd_valid_i),
    .data_i  (cmd_in),
    .pop_i   (cmd_pop),
    .data_o  (cmd_head),
    .empty_o (cmd_empty),
    .full_o  ()
  );

  opq_operand_buffer #(
    .BufferDepth (BufferDepth)
  ) operand_buffer (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .operand_i        (operand_i),
    .operand_valid_i  (operand_valid_i),
    .operand_issued_i (operand_issued_i),
    .pop_i            (ibuf_pop),
    .ready_o          (operand_queue_ready_o),
    .head_o           (ibuf_head),
    .head_valid_o     (ibuf_head_valid)
  );

  opq_sequencer sequencer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .lane_id_i    (lane_id_i),
    .cmd_i        (cmd_head),
    .head_valid_i (ibuf_head_valid),
    .fu_ready_i   (operand_ready_i),
    .valid_o      (operand_valid_o),
    .target_fu_o  (operand_target_fu_o),
    .ibuf_pop_o   (ibuf_pop),
    .cmd_pop_o    (cmd_pop),
    .conv_o       (conv_bus)
  );

  opq_convert converter (
    .conv_i    (conv_bus),
    .operand_i (ibuf_head),
    .operand_o (operand_o)
  );

  // A buffered word is only ever offered under a live command
  valid_has_cmd_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    operand_valid_o |-> !cmd_empty);

endmodule

//--- design/opq_sequencer.sv
/*
  Walks the head input word for the head command. State moves only on a transfer.
  A command with an illegal width and extension pair never advances its count.
*/
`timescale 1ns/1ps

module opq_sequencer (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic [opq_pkg::LaneIdWidth-1:0]   lane_id_i,
  input  logic [opq_pkg::CmdWidth-1:0]      cmd_i,
  input  logic                              head_valid_i,
  input  logic                              fu_ready_i,
  output logic                              valid_o,
  output logic [opq_pkg::TargetFuWidth-1:0] target_fu_o,
  output logic                              ibuf_pop_o,
  output logic                              cmd_pop_o,
  opq_conv_if.seq                           conv_o
);
  import opq_pkg::*;

  logic [ConvWidth-1:0] cmd_conv;
  logic [EewWidth-1:0]  cmd_eew;
  logic [1:0]           cmd_ntr_red;
  logic [VlWidth-1:0]   cmd_vl;
  logic [SelWidth-1:0]  select_d, select_q;
  logic [VlWidth-1:0]   count_d, count_q;
  logic [VlWidth-1:0]   word_elems;
  logic                 transfer;

  //////////////////////////////
  // Command fields
  //////////////////////////////

  assign cmd_conv    = cmd_i[CmdConvLsb +: ConvWidth];
  assign cmd_eew     = cmd_i[CmdEewLsb +: EewWidth];
  assign cmd_ntr_red = cmd_i[CmdNtrLsb +: 2];
  assign cmd_vl      = cmd_i[CmdVlLsb +: VlWidth];
  assign target_fu_o = cmd_i[CmdFuLsb +: TargetFuWidth];

  assign conv_o.conv_code = cmd_conv;
  assign conv_o.eew       = cmd_eew;
  assign conv_o.ntr_red   = cmd_ntr_red;
  assign conv_o.select    = select_q;
  assign conv_o.lane_zero = (lane_id_i == '0);

  // Source elements held in one full word
  assign word_elems = VlWidth'(ElenBytes >> cmd_eew);

  assign valid_o  = head_valid_i;
  assign transfer = head_valid_i && fu_ready_i;

  //////////////////////////////
  // Counting and pops
  //////////////////////////////

  always_comb begin
    select_d   = select_q;
    count_d    = count_q;
    ibuf_pop_o = 1'b0;
    cmd_pop_o  = 1'b0;

    if (transfer) begin
      case (cmd_conv)
        ConvSExt2, ConvZExt2: begin
          count_d  = count_q + (word_elems >> 1);
          select_d = select_q + SelWidth'(ElenBytes / 2);
        end
        ConvSExt4, ConvZExt4: begin
          count_d  = count_q + (word_elems >> 2);
          select_d = select_q + SelWidth'(ElenBytes / 4);
        end
        ConvIntRed: count_d = count_q + VlWidth'(1);
        default:    count_d = count_q + word_elems;
      endcase

      // Input word used up
      if ((select_q != '0 && select_d == '0) ||
          cmd_conv == ConvNone || cmd_conv == ConvIntRed) begin
        ibuf_pop_o = 1'b1;
      end

      // Command done, even partway through a word
      if (count_d >= cmd_vl) begin
        ibuf_pop_o = 1'b1;
        cmd_pop_o  = 1'b1;
        select_d   = '0;
        count_d    = '0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      select_q <= '0;
      count_q  <= '0;
    end else begin
      select_q <= select_d;
      count_q  <= count_d;
    end
  end

endmodule

//--- design/opq_convert.sv
/*
  Purely combinational converter. Extension reads source elements from byte select,
  illegal width and conversion pairs pass the word unchanged.
*/
`timescale 1ns/1ps

module opq_convert (
  opq_conv_if.conv                      conv_i,
  input  logic [opq_pkg::ElenWidth-1:0] operand_i,
  output logic [opq_pkg::ElenWidth-1:0] operand_o
);
  import opq_pkg::*;

  operand_word_u in_u;
  operand_word_u out_u;

  assign in_u.d    = operand_i;
  assign operand_o = out_u.d;

  always_comb begin
    logic sext;
    logic ntrh;
    logic ntrl;

    sext = (conv_i.conv_code == ConvSExt2) || (conv_i.conv_code == ConvSExt4);
    // Neutral value is ntrh followed by ntrl in every lower bit
    ntrh = conv_i.ntr_red[1];
    ntrl = conv_i.ntr_red[0];

    out_u = in_u;

    case (conv_i.conv_code)
      //////////////////////////////
      // Extension by 2
      //////////////////////////////
      ConvSExt2, ConvZExt2: begin
        case (conv_i.eew)
          EW8: begin
            for (int e = 0; e < ElenBytes / 2; e++) begin
              out_u.h[e] = {{8{sext & in_u.b[conv_i.select + e][7]}},
                            in_u.b[conv_i.select + e]};
            end
          end
          EW16: begin
            for (int e = 0; e < ElenBytes / 4; e++) begin
              out_u.w[e] = {{16{sext & in_u.h[conv_i.select[2:1] + e][15]}},
                            in_u.h[conv_i.select[2:1] + e]};
            end
          end
          EW32: begin
            out_u.d = {{32{sext & in_u.w[conv_i.select[2]][31]}},
                       in_u.w[conv_i.select[2]]};
          end
          default: ;
        endcase
      end

      //////////////////////////////
      // Extension by 4
      //////////////////////////////
      ConvSExt4, ConvZExt4: begin
        case (conv_i.eew)
          EW8: begin
            for (int e = 0; e < ElenBytes / 4; e++) begin
              out_u.w[e] = {{24{sext & in_u.b[conv_i.select + e][7]}},
                            in_u.b[conv_i.select + e]};
            end
          end
          EW16: begin
            out_u.d = {{48{sext & in_u.h[conv_i.select[2:1]][15]}},
                       in_u.h[conv_i.select[2:1]]};
          end
          default: ;
        endcase
      end

      // Integer reduction, fill with neutral values first
      ConvIntRed: begin
        case (conv_i.eew)
          EW8:     for (int e = 0; e < ElenBytes; e++) out_u.b[e] = {ntrh, {7{ntrl}}};
          EW16:    for (int e = 0; e < ElenBytes / 2; e++) out_u.h[e] = {ntrh, {15{ntrl}}};
          EW32:    for (int e = 0; e < ElenBytes / 4; e++) out_u.w[e] = {ntrh, {31{ntrl}}};
          default: out_u.d = {ntrh, {63{ntrl}}};
        endcase
        // Lane zero contributes its first element
        if (conv_i.lane_zero) begin
          case (conv_i.eew)
            EW8:     out_u.b[0] = in_u.b[0];
            EW16:    out_u.h[0] = in_u.h[0];
            EW32:    out_u.w[0] = in_u.w[0];
            default: out_u.d    = in_u.d;
          endcase
        end
      end

      default: ;
    endcase
  end

endmodule

//--- design/opq_operand_buffer.sv
/*
  Operand FIFO with issue credits. A read may only be issued while ready_o is high,
  so the FIFO always has room when the register file answers.
*/
`timescale 1ns/1ps

module opq_operand_buffer #(
  parameter int unsigned BufferDepth = 2
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic [opq_pkg::ElenWidth-1:0] operand_i,
  input  logic                          operand_valid_i,
  input  logic                          operand_issued_i,
  input  logic                          pop_i,
  output logic                          ready_o,
  output logic [opq_pkg::ElenWidth-1:0] head_o,
  output logic                          head_valid_o
);
  import opq_pkg::*;

  localparam int unsigned CreditWidth = $clog2(BufferDepth + 1);

  logic                   empty, full;
  logic [CreditWidth-1:0] credit_d, credit_q;

  opq_fifo #(
    .Width (ElenWidth),
    .Depth (BufferDepth)
  ) ibuf_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (operand_valid_i),
    .data_i  (operand_i),
    .pop_i   (pop_i),
    .data_o  (head_o),
    .empty_o (empty),
    .full_o  (full)
  );

  assign head_valid_o = !empty;

  //////////////////////////////
  // Credit counter
  //////////////////////////////

  // Counts reads in flight plus words already buffered
  assign credit_d = credit_q + CreditWidth'(operand_issued_i) - CreditWidth'(pop_i);
  assign ready_o  = (credit_q != CreditWidth'(BufferDepth));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= '0;
    end else begin
      credit_q <= credit_d;
    end
  end

  issue_needs_credit_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    operand_issued_i |-> ready_o);

  // Every buffered word was paid for by an earlier issue
  credit_covers_fifo_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_q >= (full ? CreditWidth'(BufferDepth) : CreditWidth'(!empty)));

endmodule

//--- design/opq_fifo.sv
/*
  Circular FIFO, head visible combinationally on data_o.
  Pushing when full or popping when empty is illegal and is not absorbed.
*/
`timescale 1ns/1ps

module opq_fifo #(
  parameter int unsigned Width = 8,
  parameter int unsigned Depth = 2
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             push_i,
  input  logic [Width-1:0] data_i,
  input  logic             pop_i,
  output logic [Width-1:0] data_o,
  output logic             empty_o,
  output logic             full_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  logic [Width-1:0]    mem [Depth];
  logic [PtrWidth-1:0] rd_ptr_q, wr_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                push_ok, pop_ok;

  // Wrap at Depth so non power of two depths work
  function automatic logic [PtrWidth-1:0] next_ptr(logic [PtrWidth-1:0] ptr);
    return (ptr == PtrWidth'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CntWidth'(Depth));
  assign data_o  = mem[rd_ptr_q];

  assign push_ok = push_i && !full_o;
  assign pop_ok  = pop_i && !empty_o;

  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop_ok) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({push_ok, pop_ok})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Producer and consumer must respect the fill level
  no_overflow_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !full_o);

  no_underflow_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> !empty_o);

endmodule

//--- design/opq_conv_if.sv
/*
  Conversion controls for the word at the operand buffer head.
  Values are only meaningful while a command sits in the command FIFO.
*/
`timescale 1ns/1ps

interface opq_conv_if;
  import opq_pkg::*;

  logic [ConvWidth-1:0] conv_code;
  logic [EewWidth-1:0]  eew;
  logic [1:0]           ntr_red;
  // Byte offset of the first source element
  logic [SelWidth-1:0]  select;
  logic                 lane_zero;

  modport seq (
    output conv_code, eew, ntr_red, select, lane_zero
  );

  modport conv (
    input conv_code, eew, ntr_red, select, lane_zero
  );

endinterface

//--- design/opq_pkg.sv
/*
  Shared widths, command layout and codes of the operand queue.
  Only integer conversions exist. Element widths above EW64 are not encodable.
*/
package opq_pkg;

  // Operand word geometry
  localparam int unsigned ElenWidth = 64;
  localparam int unsigned ElenBytes = ElenWidth / 8;
  localparam int unsigned SelWidth  = $clog2(ElenBytes);

  // Element count and lane number
  localparam int unsigned VlWidth     = 16;
  localparam int unsigned LaneIdWidth = 4;

  // Element width codes, one element is 8 << code bits wide
  localparam int unsigned EewWidth = 2;
  localparam logic [EewWidth-1:0] EW8  = 2'd0;
  localparam logic [EewWidth-1:0] EW16 = 2'd1;
  localparam logic [EewWidth-1:0] EW32 = 2'd2;
  localparam logic [EewWidth-1:0] EW64 = 2'd3;

  // Conversion codes
  localparam int unsigned ConvWidth = 3;
  localparam logic [ConvWidth-1:0] ConvNone   = 3'd0;
  localparam logic [ConvWidth-1:0] ConvSExt2  = 3'd1;
  localparam logic [ConvWidth-1:0] ConvZExt2  = 3'd2;
  localparam logic [ConvWidth-1:0] ConvSExt4  = 3'd3;
  localparam logic [ConvWidth-1:0] ConvZExt4  = 3'd4;
  localparam logic [ConvWidth-1:0] ConvIntRed = 3'd5;

  // Target functional unit tag
  localparam int unsigned TargetFuWidth = 2;

  //////////////////////////////
  // Packed command layout
  //////////////////////////////

  // Fields from the LSB up: conv, eew, ntr_red, vl, target unit
  localparam int unsigned CmdConvLsb = 0;
  localparam int unsigned CmdEewLsb  = CmdConvLsb + ConvWidth;
  localparam int unsigned CmdNtrLsb  = CmdEewLsb + EewWidth;
  localparam int unsigned CmdVlLsb   = CmdNtrLsb + 2;
  localparam int unsigned CmdFuLsb   = CmdVlLsb + VlWidth;
  localparam int unsigned CmdWidth   = CmdFuLsb + TargetFuWidth;

  //////////////////////////////
  // Operand word views
  //////////////////////////////

  // Same 64 bits seen as bytes, halfwords, words or one doubleword
  typedef union packed {
    logic [ElenBytes-1:0][7:0]    b;
    logic [ElenBytes/2-1:0][15:0] h;
    logic [ElenBytes/4-1:0][31:0] w;
    logic [ElenWidth-1:0]         d;
  } operand_word_u;

endpackage
